/* logic/icache_defines.svh */
/*
  instruction cache sizing macros
  geometry, address split and fetch width
  replacement LFSR width
*/

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// associativity and number of sets
`define ICACHE_WAYS 4
`define ICACHE_SETS 16
// bytes per cache line
`define ICACHE_LINE_BYTES 16

// physical fetch address and instruction word
`define ICACHE_ADDR_WIDTH 32
`define ICACHE_FETCH_WIDTH 32

// random replacement source
`define ICACHE_LFSR_WIDTH 8

// derived address split: tag | index | offset
`define ICACHE_INDEX_WIDTH ($clog2(`ICACHE_SETS))
`define ICACHE_OFFSET_WIDTH ($clog2(`ICACHE_LINE_BYTES))
`define ICACHE_TAG_WIDTH (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH)
`define ICACHE_LINE_WIDTH (`ICACHE_LINE_BYTES * 8)

`endif

/* logic/icache_pkg.sv */
/*
  instruction cache types
  address fields, line and word vectors
  way encodings and controller states
*/

`include "icache_defines.svh"

package icache_pkg;

  // address and its fields
  typedef logic [`ICACHE_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_WIDTH-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_WIDTH-1:0] offset_t;

  // payload
  typedef logic [`ICACHE_LINE_WIDTH-1:0]  line_t;
  typedef logic [`ICACHE_FETCH_WIDTH-1:0] fetch_t;

  // way number and per-way bit vector
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]         way_oh_t;

  // controller FSM
  // FLUSH clears the valid bits one set per cycle
  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

/* logic/icache_ctrl.sv */
/*
  instruction cache controller
  FSM, fetch address latch, pending flush and flush counter
  refill request and return sequencing
*/

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        fetch_req_i,
  input  addr_t       fetch_addr_i,
  output logic        fetch_ready_o,
  output logic        fetch_valid_o,
  input  logic        hit_i,
  output logic        mem_req_o,
  output addr_t       mem_addr_o,
  input  logic        mem_ack_i,
  input  logic        mem_rtrn_vld_i,
  output logic        miss_o,
  output logic        rd_en_o,
  output logic        wr_en_o,
  output index_t      index_o,
  output logic        clr_en_o,
  output index_t      clr_index_o,
  output tag_t        tag_o,
  output offset_t     offset_o,
  output logic        cmp_en_o
);

  ctrl_state_e state_d, state_q;
  addr_t       addr_q;
  logic        accept;
  logic        flush_d, flush_q;
  logic        flush_done;
  index_t      flush_cnt_d, flush_cnt_q;

  //////////////////////////////////////////////////
  // address fields
  //////////////////////////////////////////////////

  assign accept = fetch_ready_o & fetch_req_i;

  // lookup uses the incoming address, writes use the latched one
  assign index_o  = accept ? fetch_addr_i[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH]
                           : addr_q[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
  assign tag_o    = addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign offset_o = addr_q[`ICACHE_OFFSET_WIDTH-1:0];

  // refill is always line aligned
  assign mem_addr_o = {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH],
                       {`ICACHE_OFFSET_WIDTH{1'b0}}};

  // array data only valid in the cycle after a read
  assign cmp_en_o = (state_q == READ);

  // flush walks all sets
  assign clr_index_o = flush_cnt_q;
  assign flush_done  = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));
  assign flush_cnt_d = !clr_en_o  ? flush_cnt_q :
                       flush_done ? '0 :
                                    flush_cnt_q + index_t'(1);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    rd_en_o       = 1'b0;
    wr_en_o       = 1'b0;
    clr_en_o      = 1'b0;

    unique case (state_q)
      FLUSH: begin
        clr_en_o = 1'b1;
        // requests seen during the flush are absorbed
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      READ: begin
        if (hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // pipelined next lookup unless a flush waits
          if (!flush_d) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              rd_en_o = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        // return is taken unconditionally, word goes out as the line is written
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          wr_en_o       = 1'b1;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // memory side sees a held request until ack
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)))
    else $error("icache: refill request dropped or changed before ack");

  legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache: controller in illegal state");

endmodule

/* logic/icache_arrays.sv */
/*
  instruction cache storage
  per-way tag and data memories, synchronous read
  valid bit flops with per-set clear
*/

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_arrays import icache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rd_en_i,
  input  logic                        wr_en_i,
  input  index_t                      index_i,
  input  way_oh_t                     wr_way_i,
  input  tag_t                        wr_tag_i,
  input  line_t                       wr_line_i,
  input  logic                        clr_en_i,
  input  index_t                      clr_index_i,
  output tag_t  [`ICACHE_WAYS-1:0]    tag_o,
  output way_oh_t                     valid_o,
  output line_t [`ICACHE_WAYS-1:0]    line_o
);

  tag_t    tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  line_t   line_mem [`ICACHE_WAYS][`ICACHE_SETS];
  way_oh_t valid_q  [`ICACHE_SETS];

  // tag and data memories, one write port and one read port
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (wr_en_i && wr_way_i[w]) begin
        tag_mem[w][index_i]  <= wr_tag_i;
        line_mem[w][index_i] <= wr_line_i;
      end
      // read data holds until the next strobe
      if (rd_en_i) begin
        tag_o[w]  <= tag_mem[w][index_i];
        line_o[w] <= line_mem[w][index_i];
      end
    end
  end

  // valid bits
  // flush clears a whole set, a refill sets one way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
      valid_o <= '0;
    end else begin
      if (clr_en_i) begin
        valid_q[clr_index_i] <= '0;
      end else if (wr_en_i) begin
        valid_q[index_i] <= valid_q[index_i] | wr_way_i;
      end
      if (rd_en_i) begin
        valid_o <= valid_q[index_i];
      end
    end
  end

  // refill and flush come from disjoint controller states
  no_wr_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_en_i && clr_en_i))
    else $error("icache: write and clear in the same cycle");

endmodule

/* logic/icache_hit_sel.sv */
/*
  instruction cache hit select
  tag compare, hit way encode, fetch word extraction
*/

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_hit_sel import icache_pkg::*; (
  input  logic                        cmp_en_i,
  input  tag_t                        tag_i,
  input  offset_t                     offset_i,
  input  tag_t  [`ICACHE_WAYS-1:0]    way_tag_i,
  input  way_oh_t                     way_valid_i,
  input  line_t [`ICACHE_WAYS-1:0]    way_line_i,
  input  line_t                       rtrn_line_i,
  output logic                        hit_o,
  output fetch_t                      data_o
);

  way_oh_t  hit_vec;
  way_idx_t hit_idx;
  fetch_t   way_word [`ICACHE_WAYS];
  fetch_t   rtrn_word;

  // compare and word select per way
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_vec[w]  = way_valid_i[w] && (way_tag_i[w] == tag_i);
      way_word[w] = way_line_i[w][{offset_i[`ICACHE_OFFSET_WIDTH-1:2], 5'b0} +: 32];
    end
  end

  // lowest hitting way wins
  always_comb begin
    hit_idx = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_idx = way_idx_t'(w);
      end
    end
  end

  assign rtrn_word = rtrn_line_i[{offset_i[`ICACHE_OFFSET_WIDTH-1:2], 5'b0} +: 32];
  assign hit_o     = cmp_en_i & (|hit_vec);
  // refill line is bypassed to the fetch port outside compare
  assign data_o    = cmp_en_i ? way_word[hit_idx] : rtrn_word;

  // a line is never allocated twice in one set
  always_comb begin
    if (cmp_en_i) begin
      assert ($onehot0(hit_vec))
        else $error("icache: multiple ways hit");
    end
  end

endmodule

/* logic/icache_repl.sv */
/*
  instruction cache replacement picker
  lowest invalid way, else LFSR way, registered one-hot
*/

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_repl import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    cmp_en_i,
  input  logic    wr_en_i,
  input  way_oh_t way_valid_i,
  output way_oh_t wr_way_o
);

  logic [`ICACHE_LFSR_WIDTH-1:0] lfsr_q;
  logic                          lfsr_fb;
  logic                          all_valid;
  way_idx_t                      inv_way;
  way_idx_t                      repl_way;

  // first invalid way, scanning from the top so way 0 wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  assign all_valid = &way_valid_i;
  assign repl_way  = all_valid ? lfsr_q[$clog2(`ICACHE_WAYS)-1:0] : inv_way;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= `ICACHE_LFSR_WIDTH'(1);
      wr_way_o <= '0;
    end else begin
      // only random victims consume a step
      if (wr_en_i && all_valid) begin
        lfsr_q <= {lfsr_q[`ICACHE_LFSR_WIDTH-2:0], lfsr_fb};
      end
      // pick is taken while the set's valid bits are on the bus
      if (cmp_en_i) begin
        wr_way_o <= way_oh_t'(1'b1) << repl_way;
      end
    end
  end

endmodule

/* logic/icache_top.sv */
/*
  instruction cache top level
  controller, storage, hit select and replacement picker
*/

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_top import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  logic   fetch_req_i,
  input  addr_t  fetch_addr_i,
  output logic   fetch_ready_o,
  output logic   fetch_valid_o,
  output fetch_t fetch_data_o,
  output logic   mem_req_o,
  output addr_t  mem_addr_o,
  input  logic   mem_ack_i,
  input  logic   mem_rtrn_vld_i,
  input  line_t  mem_rtrn_data_i,
  output logic   miss_o
);

  // controller to arrays and hit select
  logic    rd_en, wr_en, clr_en, cmp_en, hit;
  index_t  index, clr_index;
  tag_t    tag;
  offset_t offset;

  // array read data
  tag_t  [`ICACHE_WAYS-1:0] way_tag;
  line_t [`ICACHE_WAYS-1:0] way_line;
  way_oh_t                  way_valid;
  way_oh_t                  wr_way;

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_valid_o  (fetch_valid_o),
    .hit_i          (hit),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .miss_o         (miss_o),
    .rd_en_o        (rd_en),
    .wr_en_o        (wr_en),
    .index_o        (index),
    .clr_en_o       (clr_en),
    .clr_index_o    (clr_index),
    .tag_o          (tag),
    .offset_o       (offset),
    .cmp_en_o       (cmp_en)
  );

  icache_arrays u_arrays (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .wr_en_i     (wr_en),
    .index_i     (index),
    .wr_way_i    (wr_way),
    .wr_tag_i    (tag),
    .wr_line_i   (mem_rtrn_data_i),
    .clr_en_i    (clr_en),
    .clr_index_i (clr_index),
    .tag_o       (way_tag),
    .valid_o     (way_valid),
    .line_o      (way_line)
  );

  icache_hit_sel u_hit_sel (
    .cmp_en_i    (cmp_en),
    .tag_i       (tag),
    .offset_i    (offset),
    .way_tag_i   (way_tag),
    .way_valid_i (way_valid),
    .way_line_i  (way_line),
    .rtrn_line_i (mem_rtrn_data_i),
    .hit_o       (hit),
    .data_o      (fetch_data_o)
  );

  icache_repl u_repl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmp_en_i    (cmp_en),
    .wr_en_i     (wr_en),
    .way_valid_i (way_valid),
    .wr_way_o    (wr_way)
  );

endmodule

/* tb/tb_icache.sv */
/*
  directed testbench for the instruction cache
  clock, reset, refill memory model with random delays
  fetch helpers, one task per behavior, watchdog and summary
*/

`timescale 1ns/1ps

`include "icache_defines.svh"

module tb_icache import icache_pkg::*; ();

  localparam int unsigned SEED = 32'h2d0c5216;
  // about 40 fetches of at most 16 cycles each plus two flushes fit well inside
  localparam int TIMEOUT_CYCLES = 4000;
  localparam addr_t LINE_BASE = 32'h0000_1000;
  // five tags that all map to set 8
  localparam addr_t SET_BASE = 32'h0000_5080;

  logic   clk_i, rst_ni, flush_i, fetch_req_i, fetch_ready_o, fetch_valid_o;
  addr_t  fetch_addr_i, mem_addr_o, last_req_addr;
  fetch_t fetch_data_o;
  logic   mem_req_o, mem_ack_i, mem_rtrn_vld_i, miss_o;
  line_t  mem_rtrn_data_i;
  int     cycle, errors, tests_run, tests_failed, miss_count, req_count;

  icache_top uut (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .fetch_req_i(fetch_req_i), .fetch_addr_i(fetch_addr_i),
    .fetch_ready_o(fetch_ready_o), .fetch_valid_o(fetch_valid_o),
    .fetch_data_o(fetch_data_o), .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
    .mem_ack_i(mem_ack_i), .mem_rtrn_vld_i(mem_rtrn_vld_i),
    .mem_rtrn_data_i(mem_rtrn_data_i), .miss_o(miss_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin : watchdog
    cycle = 0;
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

  // refill traffic seen by the cache and sampled mid-cycle
  initial begin : traffic_monitor
    miss_count = 0;
    req_count = 0;
    last_req_addr = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && miss_o) begin
        miss_count++;
      end
      if (rst_ni && mem_req_o && mem_ack_i) begin
        req_count++;
        last_req_addr = mem_addr_o;
      end
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic require_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("error at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic report_result(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, errors - err_start);
    end
  endtask

  // memory image where every word holds its own address
  function automatic line_t make_line(input addr_t base);
    line_t l;
    for (int i = 0; i < `ICACHE_LINE_BYTES / 4; i++) begin
      l[32*i +: 32] = base + addr_t'(4 * i);
    end
    return l;
  endfunction

  // ack after 0..5 cycles, then the line after another 0..5
  task automatic serve_refill();
    addr_t line_addr;
    int    ack_wait;
    int    rtrn_wait;
    line_addr = mem_addr_o;
    ack_wait  = $urandom_range(5, 0);
    rtrn_wait = $urandom_range(5, 0);
    repeat (ack_wait) next_cycle();
    next_cycle();
    mem_ack_i = 1'b1;
    next_cycle();
    mem_ack_i = 1'b0;
    repeat (rtrn_wait) next_cycle();
    mem_rtrn_vld_i  = 1'b1;
    mem_rtrn_data_i = make_line(line_addr);
    next_cycle();
    mem_rtrn_vld_i = 1'b0;
  endtask

  initial begin : memory_model
    void'($urandom(SEED));
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o) begin
        serve_refill();
      end
    end
  end

  // one fetch that starts and ends just after a rising edge
  task automatic fetch_word(input addr_t addr, output int misses);
    int miss_start;
    int lat;
    miss_start   = miss_count;
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    @(negedge clk_i);
    while (!fetch_ready_o) @(negedge clk_i);
    next_cycle();
    fetch_req_i = 1'b0;
    @(negedge clk_i);
    lat = 1;
    while (!fetch_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    misses = miss_count - miss_start;
    compare_value("fetch_data_o", fetch_data_o, addr);
    if (misses == 0) begin
      require_true(lat == 1, $sformatf("hit took %0d cycles instead of 1", lat));
      require_true(!mem_req_o, "refill request issued on a hit");
    end else begin
      require_true(misses == 1, "more than one miss pulse for one fetch");
      compare_value("mem_addr_o", last_req_addr, {addr[31:4], 4'h0});
      require_true(mem_rtrn_vld_i, "miss response outside the return cycle");
    end
    next_cycle();
  endtask

  task automatic count_flush(input string what);
    int low_cycles;
    low_cycles = 0;
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      low_cycles++;
      require_true(!fetch_valid_o && !mem_req_o && !miss_o,
                   "fetch or refill output active during flush");
      @(negedge clk_i);
    end
    require_true(low_cycles == `ICACHE_SETS,
                 $sformatf("%s kept ready low %0d cycles", what, low_cycles));
    next_cycle();
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_flush_test();
    int start;
    start = errors;
    count_flush("reset flush");
    require_true(req_count == 0 && miss_count == 0, "refill traffic before the first fetch");
    report_result("reset_flush", start);
  endtask

  task automatic cold_miss_test();
    int start;
    int m;
    start = errors;
    // a different word offset in each line
    for (int i = 0; i < 4; i++) begin
      fetch_word(LINE_BASE + addr_t'(20 * i), m);
      require_true(m == 1, "cold fetch did not miss exactly once");
    end
    report_result("cold_miss", start);
  endtask

  task automatic hit_after_fill_test();
    int start;
    int m;
    start = errors;
    for (int i = 0; i < 16; i++) begin
      fetch_word(LINE_BASE + addr_t'(4 * i), m);
      require_true(m == 0, "filled word missed");
    end
    report_result("hit_after_fill", start);
  endtask

  task automatic streaming_test();
    addr_t exp_q[$];
    int    start, sent, got, first_cycle, last_cycle, req_start;
    start = errors;
    sent = 0;
    got = 0;
    first_cycle = 0;
    last_cycle = 0;
    req_start = req_count;
    fetch_req_i  = 1'b1;
    fetch_addr_i = LINE_BASE;
    while (got < 16) begin
      @(negedge clk_i);
      if (fetch_valid_o) begin
        if (exp_q.size() == 0) begin
          require_true(1'b0, "response with no request outstanding");
        end else begin
          compare_value("fetch_data_o", fetch_data_o, exp_q.pop_front());
        end
        if (got == 0) begin
          first_cycle = cycle;
        end
        last_cycle = cycle;
        got++;
      end
      if (fetch_req_i && fetch_ready_o) begin
        exp_q.push_back(fetch_addr_i);
        sent++;
      end
      next_cycle();
      if (sent == 16) begin
        fetch_req_i = 1'b0;
      end else begin
        fetch_addr_i = LINE_BASE + addr_t'(4 * sent);
      end
    end
    require_true(last_cycle - first_cycle == 15, "streamed hits not one per cycle");
    require_true(req_count == req_start, "refill request while streaming hits");
    report_result("streaming", start);
  endtask

  task automatic replacement_test();
    int start;
    int m;
    int total;
    start = errors;
    total = 0;
    for (int k = 0; k < 5; k++) begin
      fetch_word(SET_BASE + (addr_t'(k) << 8), m);
      require_true(m == 1, "new tag in the set did not miss");
    end
    // rechecked newest first
    for (int k = 3; k >= 0; k--) begin
      fetch_word(SET_BASE + (addr_t'(k) << 8), m);
      total += m;
    end
    require_true(total == 1, $sformatf("%0d misses refetching four tags, expected 1", total));
    report_result("replacement", start);
  endtask

  task automatic flush_test();
    int start;
    int m;
    start = errors;
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    count_flush("flush request");
    for (int i = 0; i < 4; i++) begin
      fetch_word(LINE_BASE + addr_t'(16 * i), m);
      require_true(m == 1, "line survived the flush");
      fetch_word(LINE_BASE + addr_t'(16 * i + 8), m);
      require_true(m == 0, "refilled line missed again");
    end
    report_result("flush", start);
  endtask

  initial begin : main
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    reset_flush_test();
    cold_miss_test();
    hit_after_fill_test();
    streaming_test();
    replacement_test();
    flush_test();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_arrays.sv
logic/icache_hit_sel.sv
logic/icache_repl.sv
logic/icache_top.sv
tb/tb_icache.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_icache
FILELIST  = compile.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
